// ==== hw/mecobo_pkg.sv ====
/*
 * Shared constants for the subsystem: sizes, host register map, pin modes
 * and the command data word with its two decodings.
 */
package mecobo_pkg;

    localparam int num_pins          = 8;
    localparam int cmd_fifo_depth    = 16;
    localparam int sample_fifo_depth = 32;
    localparam int cmd_width         = 80;

    // command bus address of the sample collector
    localparam logic [15:0] collector_addr = 16'h0040;

    // host register map
    localparam logic [7:0] reg_time_lo      = 8'd0;
    localparam logic [7:0] reg_time_hi      = 8'd1;
    localparam logic [7:0] reg_cmd_addr     = 8'd2;
    localparam logic [7:0] reg_data_lo      = 8'd3;
    localparam logic [7:0] reg_data_hi      = 8'd4;
    localparam logic [7:0] reg_push         = 8'd5;
    localparam logic [7:0] reg_control      = 8'd8;
    localparam logic [7:0] reg_sample       = 8'd9;
    localparam logic [7:0] reg_sample_count = 8'd10;
    localparam logic [7:0] reg_clock_lo     = 8'd12;
    localparam logic [7:0] reg_clock_hi     = 8'd13;

    localparam logic [1:0] mode_off    = 2'd0;
    localparam logic [1:0] mode_high   = 2'd1;
    localparam logic [1:0] mode_square = 2'd2;

    // one data word, read differently by pins and by the collector
    typedef union packed {
        struct packed {
            logic [13:0] reserved;
            logic [1:0]  mode;
            logic [15:0] half_period;
        } pin_cfg;
        struct packed {
            logic [7:0]  reserved;
            logic [7:0]  channel_mask;
            logic [15:0] interval;
        } collector_cfg;
    } cmd_data_u;

endpackage

// ==== hw/sync_fifo.sv ====
/*
 * First-word-fall-through synchronous FIFO with valid/ready on both sides.
 * Used as the command FIFO and as the sample FIFO.
 */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 16
) (
    input  logic                       sys_clk,
    input  logic                       core_reset,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [WIDTH-1:0]           in_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [WIDTH-1:0]           out_data,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int ptr_width = $clog2(DEPTH);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic                 push;
    logic                 pop;

    assign in_ready  = (count != DEPTH);
    assign out_valid = (count != 0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // head is visible without a read cycle
    assign out_data = mem[rd_ptr];

    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (core_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hw/host_port.sv ====
/*
 * Host register port. Stages time-stamped commands, owns the global clock
 * and its start/stop/soft-reset control, and serves status and sample reads.
 */
`timescale 1ns/1ps

module host_port (
    input  logic        sys_clk,
    input  logic        mecobo_reset,
    input  logic [7:0]  host_addr,
    input  logic [15:0] host_wdata,
    input  logic        host_wr,
    input  logic        host_rd,
    output logic [15:0] host_rdata,
    output logic        host_irq,
    output logic        cmd_push_valid,
    output logic [79:0] cmd_push_data,
    input  logic        cmd_push_ready,
    output logic [31:0] global_clock,
    output logic        clock_running,
    output logic        soft_reset,
    input  logic [15:0] sample_head,
    input  logic        sample_valid,
    input  logic [5:0]  sample_count,
    input  logic        overflow,
    output logic        sample_pop
);

    logic [15:0] time_lo;
    logic [15:0] time_hi;
    logic [15:0] cmd_addr;
    logic [15:0] data_lo;
    logic [15:0] data_hi;
    logic        ctrl_wr;

    // staging registers, pushed as one command word
    always_ff @(posedge sys_clk) begin
        if (host_wr) begin
            case (host_addr)
                mecobo_pkg::reg_time_lo:  time_lo  <= host_wdata;
                mecobo_pkg::reg_time_hi:  time_hi  <= host_wdata;
                mecobo_pkg::reg_cmd_addr: cmd_addr <= host_wdata;
                mecobo_pkg::reg_data_lo:  data_lo  <= host_wdata;
                mecobo_pkg::reg_data_hi:  data_hi  <= host_wdata;
                default: ;
            endcase
        end
    end

    // dropped by the FIFO when it is full
    assign cmd_push_valid = host_wr && (host_addr == mecobo_pkg::reg_push);
    assign cmd_push_data  = {time_hi, time_lo, cmd_addr, data_hi, data_lo};

    assign ctrl_wr = host_wr && (host_addr == mecobo_pkg::reg_control);

    always_ff @(posedge sys_clk) begin
        if (mecobo_reset) begin
            global_clock  <= '0;
            clock_running <= 1'b0;
            soft_reset    <= 1'b0;
        end else begin
            soft_reset <= ctrl_wr && host_wdata[2];
            if (ctrl_wr && host_wdata[2]) begin
                clock_running <= 1'b0;
                global_clock  <= '0;
            end else if (ctrl_wr && host_wdata[0]) begin
                // start restarts time from zero
                clock_running <= 1'b1;
                global_clock  <= '0;
            end else if (ctrl_wr && host_wdata[1]) begin
                clock_running <= 1'b0;
            end else if (clock_running) begin
                global_clock <= global_clock + 1'b1;
            end
        end
    end

    assign sample_pop = host_rd && (host_addr == mecobo_pkg::reg_sample) && sample_valid;
    assign host_irq   = sample_valid;

    // read data appears one cycle after host_rd
    always_ff @(posedge sys_clk) begin
        if (host_rd) begin
            case (host_addr)
                mecobo_pkg::reg_control:
                    host_rdata <= {12'd0, overflow, !sample_valid, !cmd_push_ready,
                                   clock_running};
                mecobo_pkg::reg_sample:       host_rdata <= sample_valid ? sample_head : 16'd0;
                mecobo_pkg::reg_sample_count: host_rdata <= {10'd0, sample_count};
                mecobo_pkg::reg_clock_lo:     host_rdata <= global_clock[15:0];
                mecobo_pkg::reg_clock_hi:     host_rdata <= global_clock[31:16];
                default:                      host_rdata <= 16'd0;
            endcase
        end
    end

endmodule

// ==== hw/scheduler.sv ====
/*
 * Releases the head of the command FIFO onto the command bus once the
 * global clock has reached its time stamp. One command per cycle, in order.
 */
`timescale 1ns/1ps

module scheduler (
    input  logic                  sys_clk,
    input  logic                  core_reset,
    input  logic [31:0]           global_clock,
    input  logic                  clock_running,
    input  logic                  fifo_valid,
    input  logic [79:0]           fifo_data,
    output logic                  fifo_ready,
    output logic                  cmd_bus_en,
    output logic [15:0]           cmd_bus_addr,
    output mecobo_pkg::cmd_data_u cmd_bus_data
);

    logic [31:0] head_time;
    logic [15:0] head_addr;
    logic [31:0] head_data;
    logic        due;

    // command word is time, address, data from the top down
    assign head_time = fifo_data[79:48];
    assign head_addr = fifo_data[47:32];
    assign head_data = fifo_data[31:0];

    // a head that is not due holds back everything behind it
    assign due        = fifo_valid && clock_running && (head_time <= global_clock);
    assign fifo_ready = due;

    always_ff @(posedge sys_clk) begin
        if (core_reset) begin
            cmd_bus_en <= 1'b0;
        end else begin
            cmd_bus_en <= due;
        end
    end

    // bus payload only matters while the strobe is high
    always_ff @(posedge sys_clk) begin
        if (due) begin
            cmd_bus_addr <= head_addr;
            cmd_bus_data <= head_data;
        end
    end

endmodule

// ==== hw/pin_control.sv ====
/*
 * One output pin controller. A command bus write to its own position sets
 * the mode (off, high, square) and the half period of the square wave.
 */
`timescale 1ns/1ps

module pin_control #(
    parameter int POSITION = 0
) (
    input  logic                  sys_clk,
    input  logic                  core_reset,
    input  logic                  cmd_bus_en,
    input  logic [15:0]           cmd_bus_addr,
    input  mecobo_pkg::cmd_data_u cmd_bus_data,
    output logic                  pin
);

    logic [1:0]  mode;
    logic [15:0] half_period;
    logic [15:0] tick;
    logic [15:0] limit;
    logic        wave;
    logic        cfg_hit;

    assign cfg_hit = cmd_bus_en && (cmd_bus_addr == 16'(POSITION));

    // zero half period behaves like one
    assign limit = (half_period == 16'd0) ? 16'd1 : half_period;

    always_ff @(posedge sys_clk) begin
        if (core_reset) begin
            mode        <= mecobo_pkg::mode_off;
            half_period <= '0;
            tick        <= '0;
            wave        <= 1'b0;
        end else if (cfg_hit) begin
            mode        <= cmd_bus_data.pin_cfg.mode;
            half_period <= cmd_bus_data.pin_cfg.half_period;
            tick        <= '0;
            wave        <= 1'b0;
        end else if (mode == mecobo_pkg::mode_square) begin
            if (tick == limit - 1'b1) begin
                tick <= '0;
                wave <= !wave;
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    always_comb begin
        case (mode)
            mecobo_pkg::mode_high:   pin = 1'b1;
            mecobo_pkg::mode_square: pin = wave;
            // off and the unused code
            default:                 pin = 1'b0;
        endcase
    end

endmodule

// ==== hw/sample_collector.sv ====
/*
 * Periodic pin sampler. Configured over the command bus with an interval
 * and a channel mask; samples wait in a FIFO until the host reads them.
 */
`timescale 1ns/1ps

module sample_collector (
    input  logic                  sys_clk,
    input  logic                  core_reset,
    input  logic                  cmd_bus_en,
    input  logic [15:0]           cmd_bus_addr,
    input  mecobo_pkg::cmd_data_u cmd_bus_data,
    input  logic                  clock_running,
    input  logic [7:0]            pins,
    output logic [15:0]           sample_head,
    output logic                  sample_valid,
    input  logic                  sample_pop,
    output logic [5:0]            sample_count,
    output logic                  overflow
);

    logic [15:0] interval;
    logic [7:0]  channel_mask;
    logic [15:0] tick;
    logic [7:0]  seq;
    logic        cfg_hit;
    logic        enabled;
    logic        fire;
    logic        fifo_ready;

    assign cfg_hit = cmd_bus_en && (cmd_bus_addr == mecobo_pkg::collector_addr);
    assign enabled = clock_running && (channel_mask != 8'd0) && (interval != 16'd0);
    assign fire    = enabled && !cfg_hit && (tick == interval - 1'b1);

    always_ff @(posedge sys_clk) begin
        if (core_reset) begin
            interval     <= '0;
            channel_mask <= '0;
            tick         <= '0;
            seq          <= '0;
            overflow     <= 1'b0;
        end else if (cfg_hit) begin
            interval     <= cmd_bus_data.collector_cfg.interval;
            channel_mask <= cmd_bus_data.collector_cfg.channel_mask;
            tick         <= '0;
            seq          <= '0;
        end else if (enabled) begin
            if (fire) begin
                tick <= '0;
                // sequence keeps counting through dropped samples
                seq  <= seq + 1'b1;
                if (!fifo_ready) begin
                    overflow <= 1'b1;
                end
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    sync_fifo #(
        .WIDTH(16),
        .DEPTH(mecobo_pkg::sample_fifo_depth)
    ) sample_fifo_i (
        .sys_clk    (sys_clk),
        .core_reset (core_reset),
        .in_valid   (fire),
        .in_ready   (fifo_ready),
        .in_data    ({seq, pins & channel_mask}),
        .out_valid  (sample_valid),
        .out_ready  (sample_pop),
        .out_data   (sample_head),
        .count      (sample_count)
    );

endmodule

// ==== hw/mecobo.sv ====
/*
 * Top level: host port, command FIFO, scheduler, eight pin controllers and
 * the sample collector on a shared command bus.
 */
`timescale 1ns/1ps

module mecobo (
    input  logic        sys_clk,
    input  logic        mecobo_reset,
    input  logic [7:0]  host_addr,
    input  logic [15:0] host_wdata,
    input  logic        host_wr,
    input  logic        host_rd,
    output logic [15:0] host_rdata,
    output logic        host_irq,
    output wire  [7:0]  pins
);

    logic                  core_reset;
    logic                  soft_reset;
    logic                  cmd_push_valid;
    logic                  cmd_push_ready;
    logic [79:0]           cmd_push_data;
    logic [31:0]           global_clock;
    logic                  clock_running;
    logic                  sched_valid;
    logic                  sched_ready;
    logic [79:0]           sched_data;
    logic                  cmd_bus_en;
    logic [15:0]           cmd_bus_addr;
    mecobo_pkg::cmd_data_u cmd_bus_data;
    logic [15:0]           sample_head;
    logic                  sample_valid;
    logic                  sample_pop;
    logic [5:0]            sample_count;
    logic                  overflow;

    // soft reset clears everything but the host port
    assign core_reset = mecobo_reset | soft_reset;

    host_port host_port_i (
        .sys_clk        (sys_clk),
        .mecobo_reset   (mecobo_reset),
        .host_addr      (host_addr),
        .host_wdata     (host_wdata),
        .host_wr        (host_wr),
        .host_rd        (host_rd),
        .host_rdata     (host_rdata),
        .host_irq       (host_irq),
        .cmd_push_valid (cmd_push_valid),
        .cmd_push_data  (cmd_push_data),
        .cmd_push_ready (cmd_push_ready),
        .global_clock   (global_clock),
        .clock_running  (clock_running),
        .soft_reset     (soft_reset),
        .sample_head    (sample_head),
        .sample_valid   (sample_valid),
        .sample_count   (sample_count),
        .overflow       (overflow),
        .sample_pop     (sample_pop)
    );

    sync_fifo #(
        .WIDTH(mecobo_pkg::cmd_width),
        .DEPTH(mecobo_pkg::cmd_fifo_depth)
    ) cmd_fifo_i (
        .sys_clk    (sys_clk),
        .core_reset (core_reset),
        .in_valid   (cmd_push_valid),
        .in_ready   (cmd_push_ready),
        .in_data    (cmd_push_data),
        .out_valid  (sched_valid),
        .out_ready  (sched_ready),
        .out_data   (sched_data),
        .count      ()
    );

    scheduler scheduler_i (
        .sys_clk       (sys_clk),
        .core_reset    (core_reset),
        .global_clock  (global_clock),
        .clock_running (clock_running),
        .fifo_valid    (sched_valid),
        .fifo_data     (sched_data),
        .fifo_ready    (sched_ready),
        .cmd_bus_en    (cmd_bus_en),
        .cmd_bus_addr  (cmd_bus_addr),
        .cmd_bus_data  (cmd_bus_data)
    );

    // pin i answers on command bus address i
    for (genvar i = 0; i < mecobo_pkg::num_pins; i++) begin : gen_pin
        pin_control #(.POSITION(i)) pin_control_i (
            .sys_clk      (sys_clk),
            .core_reset   (core_reset),
            .cmd_bus_en   (cmd_bus_en),
            .cmd_bus_addr (cmd_bus_addr),
            .cmd_bus_data (cmd_bus_data),
            .pin          (pins[i])
        );
    end

    sample_collector sample_collector_i (
        .sys_clk       (sys_clk),
        .core_reset    (core_reset),
        .cmd_bus_en    (cmd_bus_en),
        .cmd_bus_addr  (cmd_bus_addr),
        .cmd_bus_data  (cmd_bus_data),
        .clock_running (clock_running),
        .pins          (pins),
        .sample_head   (sample_head),
        .sample_valid  (sample_valid),
        .sample_pop    (sample_pop),
        .sample_count  (sample_count),
        .overflow      (overflow)
    );

endmodule

// ==== test/tb_clock.sv ====
/*
 * Testbench clock and reset source: 40 ns sys_clk, reset held for 8 cycles
 * and released on a falling edge.
 */
`timescale 1ns/1ps

module tb_clock (
    output logic sys_clk,
    output logic mecobo_reset
);

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    initial begin
        mecobo_reset = 1'b1;
        repeat (8) @(posedge sys_clk);
        @(negedge sys_clk);
        mecobo_reset = 1'b0;
    end

endmodule

// ==== test/mecobo_tb.sv ====
/*
 * Testbench for the mecobo subsystem. Host accesses come from an LFSR; a pin
 * model checks command timing, square waves, FIFO limits and sampling.
 */
`timescale 1ns/1ps

module mecobo_tb;

    localparam int push_cycles   = 12;
    localparam int timed_cmds    = 6;
    localparam int max_gap       = 36;
    localparam int square_watch  = 120;
    localparam int num_samples   = 6;
    localparam int max_interval  = 23;
    // due cycle, strobe cycle, then the pin follows
    localparam int issue_latency = 2;
    // only comes due well after the soft reset
    localparam int pending_stamp = 64;
    localparam int watchdog_cycles = 2 * (timed_cmds * (push_cycles + max_gap)
        + 3 * mecobo_pkg::num_pins * push_cycles + square_watch
        + (mecobo_pkg::cmd_fifo_depth + 2) * (push_cycles + 2)
        + (num_samples + mecobo_pkg::sample_fifo_depth + 2) * max_interval
        + pending_stamp) + 500;

    logic        sys_clk;
    logic        mecobo_reset;
    logic [7:0]  host_addr;
    logic [15:0] host_wdata;
    logic        host_wr;
    logic        host_rd;
    logic [15:0] host_rdata;
    logic        host_irq;
    logic [7:0]  pins;

    logic [31:0] lfsr_state;
    logic        irq_at_read;
    int          errors;
    logic [1:0]  model_mode [8];
    logic [15:0] model_half [8];
    // commands expected to reach the pins in push order
    int          trk_time [$];
    int          trk_pin [$];
    logic [1:0]  trk_mode [$];

    tb_clock clock_gen_i (
        .sys_clk      (sys_clk),
        .mecobo_reset (mecobo_reset)
    );

    mecobo mecobo_i (
        .sys_clk      (sys_clk),
        .mecobo_reset (mecobo_reset),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .host_wr      (host_wr),
        .host_rd      (host_rd),
        .host_rdata   (host_rdata),
        .host_irq     (host_irq),
        .pins         (pins)
    );

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] pin_word(input logic [1:0] mode, input logic [15:0] half);
        return {14'd0, mode, half};
    endfunction

    task automatic report_failure(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic host_write(input logic [7:0] addr, input logic [15:0] data);
        @(negedge sys_clk);
        host_addr  = addr;
        host_wdata = data;
        host_wr    = 1'b1;
        @(negedge sys_clk);
        host_wr = 1'b0;
    endtask

    // irq is taken in the same cycle the read register samples
    task automatic host_read(input logic [7:0] addr, output logic [15:0] data);
        @(negedge sys_clk);
        host_addr   = addr;
        host_rd     = 1'b1;
        irq_at_read = host_irq;
        @(negedge sys_clk);
        host_rd = 1'b0;
        data    = host_rdata;
    endtask

    task automatic push_command(input logic [31:0] stamp, input logic [15:0] addr,
                                input logic [31:0] data);
        host_write(mecobo_pkg::reg_time_lo, stamp[15:0]);
        host_write(mecobo_pkg::reg_time_hi, stamp[31:16]);
        host_write(mecobo_pkg::reg_cmd_addr, addr);
        host_write(mecobo_pkg::reg_data_lo, data[15:0]);
        host_write(mecobo_pkg::reg_data_hi, data[31:16]);
        host_write(mecobo_pkg::reg_push, 16'd0);
    endtask

    task automatic check_pins(input int cycle);
        for (int i = 0; i < mecobo_pkg::num_pins; i++) begin
            if (model_mode[i] != mecobo_pkg::mode_square) begin
                assert (pins[i] === (model_mode[i] == mecobo_pkg::mode_high))
                else report_failure($sformatf("pin %0d is %b at cycle %0d, model mode %0d",
                                              i, pins[i], cycle, model_mode[i]));
            end
        end
    endtask

    // cycle 0 is the falling edge right after the start write
    task automatic track_commands(input int cycles);
        int k;
        k = 0;
        for (int c = 0; c <= cycles; c++) begin
            while (k < trk_time.size() && trk_time[k] + issue_latency <= c) begin
                model_mode[trk_pin[k]] = trk_mode[k];
                k++;
            end
            check_pins(c);
            @(negedge sys_clk);
        end
    endtask

    task automatic wait_for_samples(input int target, input int max_polls);
        logic [15:0] count;
        count = '0;
        for (int p = 0; count < target; p++) begin
            assert (p < max_polls)
            else report_failure("sample FIFO did not reach the expected fill level in time");
            host_read(mecobo_pkg::reg_sample_count, count);
            assert (irq_at_read == (count != 0))
            else report_failure($sformatf("host_irq %b with sample count %0d",
                                          irq_at_read, count));
        end
    endtask

    task automatic check_command_timing();
        int          stamp;
        int          pin;
        logic [15:0] clk_lo;
        stamp = 0;
        trk_time.delete();
        trk_pin.delete();
        trk_mode.delete();
        for (int k = 0; k < timed_cmds; k++) begin
            stamp = stamp + 5 + int'(take_bits(5));
            pin   = int'(take_bits(3));
            push_command(stamp, pin, pin_word(mecobo_pkg::mode_high, 16'd0));
            trk_time.push_back(stamp);
            trk_pin.push_back(pin);
            trk_mode.push_back(mecobo_pkg::mode_high);
        end
        host_write(mecobo_pkg::reg_control, 16'h0001);
        track_commands(stamp + issue_latency + 4);
        host_read(mecobo_pkg::reg_clock_lo, clk_lo);
        assert (int'(clk_lo) > stamp)
        else report_failure($sformatf("global clock %0d not past last stamp %0d",
                                      clk_lo, stamp));
        foreach (trk_pin[k]) begin
            assert (pins[trk_pin[k]] === 1'b1)
            else report_failure($sformatf("pin %0d not high after its time stamp", trk_pin[k]));
        end
    endtask

    task automatic check_square_wave();
        logic [7:0]  last_level;
        logic [15:0] half;
        int          last_edge [8];
        int          toggles [8];
        for (int i = 0; i < mecobo_pkg::num_pins; i++) begin
            half = 16'(1 + int'(take_bits(5)) % 20);
            push_command(0, i, pin_word(mecobo_pkg::mode_square, half));
            model_mode[i] = mecobo_pkg::mode_square;
            model_half[i] = half;
            last_edge[i]  = -1;
            toggles[i]    = 0;
        end
        repeat (4) @(negedge sys_clk);
        last_level = pins;
        for (int c = 0; c < square_watch; c++) begin
            @(negedge sys_clk);
            for (int i = 0; i < mecobo_pkg::num_pins; i++) begin
                if (pins[i] != last_level[i]) begin
                    if (last_edge[i] >= 0) begin
                        assert (c - last_edge[i] == int'(model_half[i]))
                        else report_failure($sformatf("pin %0d toggled after %0d cycles, half %0d",
                                                      i, c - last_edge[i], model_half[i]));
                    end
                    last_edge[i] = c;
                    toggles[i]++;
                end
            end
            last_level = pins;
        end
        for (int i = 0; i < mecobo_pkg::num_pins; i++) begin
            assert (toggles[i] >= 2)
            else report_failure($sformatf("pin %0d is not toggling in square mode", i));
        end
    endtask

    task automatic check_order_and_backpressure();
        logic [15:0] status;
        logic [1:0]  mode;
        int          pin;
        int          accepted;
        accepted = 0;
        trk_time.delete();
        trk_pin.delete();
        trk_mode.delete();
        host_write(mecobo_pkg::reg_control, 16'h0002);
        for (int k = 0; k < 2 * mecobo_pkg::cmd_fifo_depth; k++) begin
            host_read(mecobo_pkg::reg_control, status);
            if (status[1]) begin
                break;
            end
            pin  = int'(take_bits(3));
            mode = take_bits(1) ? mecobo_pkg::mode_high : mecobo_pkg::mode_off;
            push_command(k, pin, pin_word(mode, 16'd0));
            trk_time.push_back(k);
            trk_pin.push_back(pin);
            trk_mode.push_back(mode);
            accepted++;
        end
        assert (accepted == mecobo_pkg::cmd_fifo_depth)
        else report_failure($sformatf("%0d pushes accepted before full", accepted));
        // would flip the last pin if the full FIFO took it
        mode = (trk_mode[$] == mecobo_pkg::mode_high) ? mecobo_pkg::mode_off
                                                      : mecobo_pkg::mode_high;
        push_command(accepted, trk_pin[$], pin_word(mode, 16'd0));
        host_write(mecobo_pkg::reg_control, 16'h0001);
        track_commands(accepted + issue_latency + 8);
    endtask

    task automatic check_sampling();
        logic [7:0]  level;
        logic [7:0]  mask;
        logic [15:0] interval;
        logic [15:0] word;
        logic [1:0]  mode;
        level = '0;
        for (int i = 0; i < mecobo_pkg::num_pins; i++) begin
            mode = take_bits(1) ? mecobo_pkg::mode_high : mecobo_pkg::mode_off;
            push_command(0, i, pin_word(mode, 16'd0));
            model_mode[i] = mode;
            level[i]      = (mode == mecobo_pkg::mode_high);
        end
        repeat (4) @(negedge sys_clk);
        assert (pins == level)
        else report_failure($sformatf("pins %h, model %h", pins, level));
        mask = take_bits(8);
        if (mask == 8'd0) begin
            mask = 8'h01;
        end
        interval = 16'(8 + int'(take_bits(4)));
        push_command(0, mecobo_pkg::collector_addr, {8'd0, mask, interval});
        for (int s = 0; s < num_samples; s++) begin
            wait_for_samples(1, 2 * max_interval);
            host_read(mecobo_pkg::reg_sample, word);
            assert (word == {8'(s), level & mask})
            else report_failure($sformatf("sample %0d is %h, expected %h",
                                          s, word, {8'(s), level & mask}));
        end
    endtask

    task automatic check_overflow_and_soft_reset();
        logic [15:0] status;
        logic [15:0] count;
        wait_for_samples(mecobo_pkg::sample_fifo_depth,
                         mecobo_pkg::sample_fifo_depth * max_interval);
        status = '0;
        for (int p = 0; !status[3]; p++) begin
            assert (p < 2 * max_interval)
            else report_failure("overflow bit never set after the sample FIFO filled");
            host_read(mecobo_pkg::reg_control, status);
        end
        host_read(mecobo_pkg::reg_sample_count, count);
        assert (count == mecobo_pkg::sample_fifo_depth && !status[2])
        else report_failure($sformatf("full sample FIFO reports count %0d, status %h",
                                      count, status));
        // pending commands must be flushed by the soft reset
        host_write(mecobo_pkg::reg_control, 16'h0001);
        push_command(pending_stamp, 0, pin_word(mecobo_pkg::mode_high, 16'd0));
        push_command(pending_stamp, 1, pin_word(mecobo_pkg::mode_high, 16'd0));
        host_write(mecobo_pkg::reg_control, 16'h0004);
        host_read(mecobo_pkg::reg_control, status);
        assert (status[3:0] == 4'b0100)
        else report_failure($sformatf("status %h after soft reset", status));
        host_read(mecobo_pkg::reg_sample_count, count);
        assert (count == 0 && !irq_at_read && pins == 8'd0)
        else report_failure($sformatf("soft reset left count %0d, irq %b, pins %h",
                                      count, irq_at_read, pins));
        for (int i = 0; i < mecobo_pkg::num_pins; i++) begin
            model_mode[i] = mecobo_pkg::mode_off;
        end
        trk_time.delete();
        trk_pin.delete();
        trk_mode.delete();
        host_write(mecobo_pkg::reg_control, 16'h0001);
        track_commands(pending_stamp + issue_latency + 4);
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge sys_clk);
        $display("[ERROR] %0t ns: watchdog expired, the run did not finish in time", $time);
        $display("Test FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        host_addr   = '0;
        host_wdata  = '0;
        host_wr     = 1'b0;
        host_rd     = 1'b0;
        irq_at_read = 1'b0;
        errors      = 0;
        lfsr_state  = 32'heb09d238;
        for (int i = 0; i < mecobo_pkg::num_pins; i++) begin
            model_mode[i] = mecobo_pkg::mode_off;
            model_half[i] = '0;
        end
        wait (mecobo_reset == 1'b0);
        @(negedge sys_clk);
        assert (pins == 8'd0 && host_irq == 1'b0)
        else report_failure("pins or host_irq not low after reset");
        check_command_timing();
        check_square_wave();
        check_order_and_backpressure();
        check_sampling();
        check_overflow_and_soft_reset();
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/mecobo_pkg.sv
hw/sync_fifo.sv
hw/host_port.sv
hw/scheduler.sv
hw/pin_control.sv
hw/sample_collector.sv
hw/mecobo.sv
test/tb_clock.sv
test/mecobo_tb.sv
